//--- compile.f
logic/cpuPkg.sv
logic/FetchStage.sv
logic/DecodeStage.sv
logic/ExecuteStage.sv
logic/MemoryStage.sv
logic/CPU.sv
testbench/cpuTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := cpuTb
FILELIST  := compile.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/cpuTests.dat
# columns: tag, then two hex values. I word-address instruction, R register value,
# S byte-address value. expected events are listed in program order.
I 00 00500093  # addi x1, x0, 5
I 01 ffd00113  # addi x2, x0, -3
I 02 002081b3  # add  x3, x1, x2
I 03 40118233  # sub  x4, x3, x1
I 04 003222b3  # slt  x5, x4, x3
I 05 0041a333  # slt  x6, x3, x4
I 06 0f017413  # andi x8, x2, 0xf0
I 07 fe442e23  # sw   x4, -4(x8)
I 08 0a02e493  # ori  x9, x5, 0xa0
I 09 00942423  # sw   x9, 8(x8)
I 0a 00108033  # add  x0, x1, x1
I 0b 00000000  # zero word
I 0c ffffffff  # unknown opcode
I 0d ffc42503  # lw   x10, -4(x8)
I 0e 001505b3  # add  x11, x10, x1
I 0f 00842603  # lw   x12, 8(x8)
I 10 000606b3  # add  x13, x12, x0
I 11 0046f733  # and  x14, x13, x4
R 01 00000005
R 02 fffffffd
R 03 00000002
R 04 fffffffd
R 05 00000001
R 06 00000000
R 08 000000f0
R 09 000000a1
R 0a fffffffd
R 0b 00000002
R 0c 000000a1
R 0d 000000a1
R 0e 000000a1
S 000000ec fffffffd
S 000000f8 000000a1

//--- testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
  import cpuPkg::*;

  logic                     clk;
  logic                     arstN;
  logic                     run;
  logic                     imemLoad;
  logic [imemAddrWidth-1:0] imemLoadAddress;
  logic [xlen-1:0]          imemLoadData;
  logic                     retireValid;
  logic [regIndexWidth-1:0] retireIndex;
  logic [xlen-1:0]          retireData;
  logic                     storeValid;
  logic [xlen-1:0]          storeAddress;
  logic [xlen-1:0]          storeData;

  logic [xlen-1:0]          programImage [imemDepth];
  logic [regIndexWidth-1:0] expectedRetireIndex [$];
  logic [xlen-1:0]          expectedRetireData [$];
  logic [xlen-1:0]          expectedStoreAddress [$];
  logic [xlen-1:0]          expectedStoreData [$];

  CPU CPU_inst (
    .clk(clk), .arstN(arstN), .run(run),
    .imemLoad(imemLoad), .imemLoadAddress(imemLoadAddress), .imemLoadData(imemLoadData),
    .retireValid(retireValid), .retireIndex(retireIndex), .retireData(retireData),
    .storeValid(storeValid), .storeAddress(storeAddress), .storeData(storeData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // failure reporting and result checks
  // --------------------------------------------------
  task automatic stopRun();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic abortRun(input string reason);
    $display("%s at %0t ns", reason, $time);
    stopRun();
  endtask

  task automatic checkRetire(input logic [regIndexWidth-1:0] index, input logic [xlen-1:0] data);
    logic [regIndexWidth-1:0] wantIndex;
    logic [xlen-1:0]          wantData;
    wantIndex = expectedRetireIndex.pop_front();
    wantData  = expectedRetireData.pop_front();
    if (index !== wantIndex) begin
      $display("[FAIL] %0t ns retireIndex expected %0d got %0d", $time, wantIndex, index);
      stopRun();
    end
    if (data !== wantData) begin
      $display("[FAIL] %0t ns retireData expected %h got %h", $time, wantData, data);
      stopRun();
    end
  endtask

  task automatic checkStore(input logic [xlen-1:0] address, input logic [xlen-1:0] data);
    logic [xlen-1:0] wantAddress;
    logic [xlen-1:0] wantData;
    wantAddress = expectedStoreAddress.pop_front();
    wantData    = expectedStoreData.pop_front();
    if (address !== wantAddress) begin
      $display("[FAIL] %0t ns storeAddress expected %h got %h", $time, wantAddress, address);
      stopRun();
    end
    if (data !== wantData) begin
      $display("[FAIL] %0t ns storeData expected %h got %h", $time, wantData, data);
      stopRun();
    end
  endtask

  // --------------------------------------------------
  // data file and program loading
  // --------------------------------------------------
  task automatic readTests();
    int               fd;
    int               code;
    int               address;
    logic [7:0]       tag;
    logic [8*200-1:0] rest;
    logic [31:0]      first;
    logic [31:0]      second;
    for (address = 0; address < imemDepth; address++) programImage[address] = '0;
    fd = $fopen("testbench/cpuTests.dat", "r");
    if (fd == 0) abortRun("cannot open testbench/cpuTests.dat");
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(rest, fd); // rest of the line is a remark.
      end else begin
        code = $fscanf(fd, "%h %h", first, second);
        if (code != 2) abortRun("malformed line in the data file");
        if (tag == "I" && first < imemDepth) begin
          programImage[first[imemAddrWidth-1:0]] = second;
        end else if (tag == "R") begin
          expectedRetireIndex.push_back(first[regIndexWidth-1:0]);
          expectedRetireData.push_back(second);
        end else if (tag == "S") begin
          expectedStoreAddress.push_back(first);
          expectedStoreData.push_back(second);
        end else begin
          abortRun("unknown tag or program address out of range in the data file");
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic loadProgram();
    int address;
    for (address = 0; address < imemDepth; address++) begin
      @(posedge clk);
      #1;
      imemLoad        = 1'b1;
      imemLoadAddress = address[imemAddrWidth-1:0];
      imemLoadData    = programImage[address];
    end
    @(posedge clk);
    #1 imemLoad = 1'b0;
  endtask

  task automatic waitForDrain();
    int cycles;
    cycles = 0;
    while ((expectedRetireIndex.size() != 0 || expectedStoreAddress.size() != 0)
           && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (expectedRetireIndex.size() != 0) begin
      abortRun($sformatf("timeout with %0d retire events still expected",
                         expectedRetireIndex.size()));
    end else if (expectedStoreAddress.size() != 0) begin
      abortRun($sformatf("timeout with %0d store events still expected",
                         expectedStoreAddress.size()));
    end
  endtask

  // outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (!run) begin
      if (retireValid !== 1'b0 || storeValid !== 1'b0) begin
        abortRun("trace output active before the program was started");
      end
    end else begin
      if (retireValid && expectedRetireIndex.size() == 0) begin
        abortRun("retire pulse with no retire event left to expect");
      end else if (retireValid) begin
        checkRetire(retireIndex, retireData);
      end
      if (storeValid && expectedStoreAddress.size() == 0) begin
        abortRun("store pulse with no store event left to expect");
      end else if (storeValid) begin
        checkStore(storeAddress, storeData);
      end
    end
  end

  initial begin
    arstN           = 1'b0;
    run             = 1'b0;
    imemLoad        = 1'b0;
    imemLoadAddress = '0;
    imemLoadData    = '0;
    readTests();
    repeat (8) @(posedge clk);
    #1 arstN = 1'b1;
    loadProgram();
    @(posedge clk);
    #1 run = 1'b1;
    waitForDrain();
    repeat (20) @(posedge clk); // a late or repeated event shows up as an extra pulse.
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- logic/CPU.sv
`timescale 1ns/1ps

module CPU (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic                             run,
  input  logic                             imemLoad,
  input  logic [cpuPkg::imemAddrWidth-1:0] imemLoadAddress,
  input  logic [cpuPkg::xlen-1:0]          imemLoadData,
  output logic                             retireValid,
  output logic [cpuPkg::regIndexWidth-1:0] retireIndex,
  output logic [cpuPkg::xlen-1:0]          retireData,
  output logic                             storeValid,
  output logic [cpuPkg::xlen-1:0]          storeAddress,
  output logic [cpuPkg::xlen-1:0]          storeData
);
  import cpuPkg::*;

  instrWord                 idInstruction;
  logic                     idValid;
  logic                     stall;

  logic [xlen-1:0]          exLhsValue;
  logic [xlen-1:0]          exRhsValue;
  logic [regIndexWidth-1:0] exLhsIndex;
  logic [regIndexWidth-1:0] exRhsIndex;
  logic [regIndexWidth-1:0] exWriteIndex;
  logic [xlen-1:0]          exImmediate;
  logic [2:0]               exFunct3;
  logic [6:0]               exFunct7;
  logic [1:0]               exAluOp;
  logic                     exAluSrc;
  logic                     exMemRead;
  logic                     exMemWrite;
  logic                     exMemToReg;
  logic                     exRegWrite;

  logic [xlen-1:0]          memAluResult;
  logic [xlen-1:0]          memStoreData;
  logic [regIndexWidth-1:0] memWriteIndex;
  logic                     memMemRead;
  logic                     memMemWrite;
  logic                     memMemToReg;
  logic                     memRegWrite;

  logic                     wbWrite; // already qualified by a nonzero index.
  logic [regIndexWidth-1:0] wbIndex;
  logic [xlen-1:0]          wbData;

  FetchStage fetchStage (
    .clk(clk), .arstN(arstN), .run(run), .stall(stall),
    .imemLoad(imemLoad), .imemLoadAddress(imemLoadAddress), .imemLoadData(imemLoadData),
    .idInstruction(idInstruction), .idValid(idValid)
  );

  DecodeStage decodeStage (
    .clk(clk), .arstN(arstN),
    .idInstruction(idInstruction), .idValid(idValid),
    .wbWrite(wbWrite), .wbIndex(wbIndex), .wbData(wbData),
    .stall(stall),
    .exLhsValue(exLhsValue), .exRhsValue(exRhsValue),
    .exLhsIndex(exLhsIndex), .exRhsIndex(exRhsIndex), .exWriteIndex(exWriteIndex),
    .exImmediate(exImmediate), .exFunct3(exFunct3), .exFunct7(exFunct7),
    .exAluOp(exAluOp), .exAluSrc(exAluSrc), .exMemRead(exMemRead),
    .exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exRegWrite(exRegWrite)
  );

  ExecuteStage executeStage (
    .clk(clk), .arstN(arstN),
    .exLhsValue(exLhsValue), .exRhsValue(exRhsValue),
    .exLhsIndex(exLhsIndex), .exRhsIndex(exRhsIndex), .exWriteIndex(exWriteIndex),
    .exImmediate(exImmediate), .exFunct3(exFunct3), .exFunct7(exFunct7),
    .exAluOp(exAluOp), .exAluSrc(exAluSrc), .exMemRead(exMemRead),
    .exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exRegWrite(exRegWrite),
    .wbWrite(wbWrite), .wbIndex(wbIndex), .wbData(wbData),
    .memAluResult(memAluResult), .memStoreData(memStoreData),
    .memWriteIndex(memWriteIndex), .memMemRead(memMemRead), .memMemWrite(memMemWrite),
    .memMemToReg(memMemToReg), .memRegWrite(memRegWrite)
  );

  MemoryStage memoryStage (
    .clk(clk), .arstN(arstN),
    .memAluResult(memAluResult), .memStoreData(memStoreData),
    .memWriteIndex(memWriteIndex), .memMemRead(memMemRead), .memMemWrite(memMemWrite),
    .memMemToReg(memMemToReg), .memRegWrite(memRegWrite),
    .wbWrite(wbWrite), .wbIndex(wbIndex), .wbData(wbData),
    .retireValid(retireValid), .retireIndex(retireIndex), .retireData(retireData),
    .storeValid(storeValid), .storeAddress(storeAddress), .storeData(storeData)
  );

endmodule

//--- logic/MemoryStage.sv
`timescale 1ns/1ps

module MemoryStage (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [cpuPkg::xlen-1:0]          memAluResult,
  input  logic [cpuPkg::xlen-1:0]          memStoreData,
  input  logic [cpuPkg::regIndexWidth-1:0] memWriteIndex,
  input  logic                             memMemRead,
  input  logic                             memMemWrite,
  input  logic                             memMemToReg,
  input  logic                             memRegWrite,
  output logic                             wbWrite,
  output logic [cpuPkg::regIndexWidth-1:0] wbIndex,
  output logic [cpuPkg::xlen-1:0]          wbData,
  output logic                             retireValid,
  output logic [cpuPkg::regIndexWidth-1:0] retireIndex,
  output logic [cpuPkg::xlen-1:0]          retireData,
  output logic                             storeValid,
  output logic [cpuPkg::xlen-1:0]          storeAddress,
  output logic [cpuPkg::xlen-1:0]          storeData
);
  import cpuPkg::*;

  logic [xlen-1:0]          dataMemory [dmemDepth];
  logic [dmemAddrWidth-1:0] wordAddress;
  logic [xlen-1:0]          readData;
  logic [xlen-1:0]          wbMemoryData;
  logic [xlen-1:0]          wbAluResult;
  logic                     wbRegWrite;
  logic                     wbMemToReg;

  assign wordAddress = memAluResult[dmemAddrWidth+1:2];
  assign readData    = memMemRead ? dataMemory[wordAddress] : '0;

  always_ff @(posedge clk) begin
    if (memMemWrite) begin
      dataMemory[wordAddress] <= memStoreData;
    end
  end

  // --------------------------------------------------
  // memory/writeback register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
    end else begin
      wbRegWrite <= memRegWrite;
      wbMemToReg <= memMemToReg;
    end
  end

  always_ff @(posedge clk) begin
    wbMemoryData <= readData;
    wbAluResult  <= memAluResult;
    wbIndex      <= memWriteIndex;
  end

  assign wbWrite = wbRegWrite && (wbIndex != '0); // a write to x0 is dropped here.
  assign wbData  = wbMemToReg ? wbMemoryData : wbAluResult;

  // trace ports.
  assign retireValid  = wbWrite;
  assign retireIndex  = wbIndex;
  assign retireData   = wbData;
  assign storeValid   = memMemWrite;
  assign storeAddress = memAluResult;
  assign storeData    = memStoreData;

endmodule

//--- logic/ExecuteStage.sv
`timescale 1ns/1ps

module ExecuteStage (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [cpuPkg::xlen-1:0]          exLhsValue,
  input  logic [cpuPkg::xlen-1:0]          exRhsValue,
  input  logic [cpuPkg::regIndexWidth-1:0] exLhsIndex,
  input  logic [cpuPkg::regIndexWidth-1:0] exRhsIndex,
  input  logic [cpuPkg::regIndexWidth-1:0] exWriteIndex,
  input  logic [cpuPkg::xlen-1:0]          exImmediate,
  input  logic [2:0]                       exFunct3,
  input  logic [6:0]                       exFunct7,
  input  logic [1:0]                       exAluOp,
  input  logic                             exAluSrc,
  input  logic                             exMemRead,
  input  logic                             exMemWrite,
  input  logic                             exMemToReg,
  input  logic                             exRegWrite,
  input  logic                             wbWrite,
  input  logic [cpuPkg::regIndexWidth-1:0] wbIndex,
  input  logic [cpuPkg::xlen-1:0]          wbData,
  output logic [cpuPkg::xlen-1:0]          memAluResult,
  output logic [cpuPkg::xlen-1:0]          memStoreData,
  output logic [cpuPkg::regIndexWidth-1:0] memWriteIndex,
  output logic                             memMemRead,
  output logic                             memMemWrite,
  output logic                             memMemToReg,
  output logic                             memRegWrite
);
  import cpuPkg::*;

  logic [1:0]      lhsSelect;
  logic [1:0]      rhsSelect;
  logic [xlen-1:0] lhsOperand;
  logic [xlen-1:0] rhsForwarded;
  logic [xlen-1:0] rhsOperand;
  logic [3:0]      aluControl;
  logic [xlen-1:0] aluResult;

  // --------------------------------------------------
  // forwarding with priority to the younger memory stage
  // --------------------------------------------------
  function automatic logic [1:0] forwardSelect(
    input logic [regIndexWidth-1:0] readIndex,
    input logic                     memHitEnable,
    input logic [regIndexWidth-1:0] memIndex,
    input logic                     wbHitEnable,
    input logic [regIndexWidth-1:0] wbHitIndex
  );
    if (readIndex == '0) return fwdNone;
    if (memHitEnable && memIndex == readIndex) return fwdMemory;
    if (wbHitEnable && wbHitIndex == readIndex) return fwdWriteback;
    return fwdNone;
  endfunction

  function automatic logic [xlen-1:0] forwardValue(
    input logic [1:0]      select,
    input logic [xlen-1:0] registerValue,
    input logic [xlen-1:0] memValue,
    input logic [xlen-1:0] wbValue
  );
    case (select)
      fwdMemory:    return memValue;
      fwdWriteback: return wbValue;
      default:      return registerValue;
    endcase
  endfunction

  assign lhsSelect = forwardSelect(exLhsIndex, memRegWrite, memWriteIndex, wbWrite, wbIndex);
  assign rhsSelect = forwardSelect(exRhsIndex, memRegWrite, memWriteIndex, wbWrite, wbIndex);

  assign lhsOperand   = forwardValue(lhsSelect, exLhsValue, memAluResult, wbData);
  assign rhsForwarded = forwardValue(rhsSelect, exRhsValue, memAluResult, wbData);
  assign rhsOperand   = exAluSrc ? exImmediate : rhsForwarded; // stores keep rhsForwarded.

  // --------------------------------------------------
  // ALU control and ALU
  // --------------------------------------------------
  always_comb begin
    aluControl = aluAdd; // loads and stores compute base plus offset.
    if (exAluOp != aluOpMem) begin
      case (exFunct3)
        3'b000: if (exAluOp == aluOpReg && exFunct7[5]) aluControl = aluSub;
        3'b010: aluControl = aluSlt;
        3'b110: aluControl = aluOr;
        3'b111: aluControl = aluAnd;
        default: aluControl = aluAdd;
      endcase
    end
  end

  always_comb begin
    case (aluControl)
      aluSub:  aluResult = lhsOperand - rhsOperand;
      aluAnd:  aluResult = lhsOperand & rhsOperand;
      aluOr:   aluResult = lhsOperand | rhsOperand;
      aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(lhsOperand) < $signed(rhsOperand)};
      default: aluResult = lhsOperand + rhsOperand;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memAluResult  <= '0;
      memStoreData  <= '0;
      memWriteIndex <= '0;
      {memMemRead, memMemWrite, memMemToReg, memRegWrite} <= '0;
    end else begin
      memAluResult  <= aluResult;
      memStoreData  <= rhsForwarded;
      memWriteIndex <= exWriteIndex;
      {memMemRead, memMemWrite, memMemToReg, memRegWrite} <=
        {exMemRead, exMemWrite, exMemToReg, exRegWrite};
    end
  end

endmodule

//--- logic/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage (
  input  logic                             clk,
  input  logic                             arstN,
  input  cpuPkg::instrWord                 idInstruction,
  input  logic                             idValid,
  input  logic                             wbWrite,
  input  logic [cpuPkg::regIndexWidth-1:0] wbIndex,
  input  logic [cpuPkg::xlen-1:0]          wbData,
  output logic                             stall,
  output logic [cpuPkg::xlen-1:0]          exLhsValue,
  output logic [cpuPkg::xlen-1:0]          exRhsValue,
  output logic [cpuPkg::regIndexWidth-1:0] exLhsIndex,
  output logic [cpuPkg::regIndexWidth-1:0] exRhsIndex,
  output logic [cpuPkg::regIndexWidth-1:0] exWriteIndex,
  output logic [cpuPkg::xlen-1:0]          exImmediate,
  output logic [2:0]                       exFunct3,
  output logic [6:0]                       exFunct7,
  output logic [1:0]                       exAluOp,
  output logic                             exAluSrc,
  output logic                             exMemRead,
  output logic                             exMemWrite,
  output logic                             exMemToReg,
  output logic                             exRegWrite
);
  import cpuPkg::*;

  logic [xlen-1:0]          registers [32];
  logic [regIndexWidth-1:0] lhsIndex;
  logic [regIndexWidth-1:0] rhsIndex;
  logic [xlen-1:0]          lhsValue;
  logic [xlen-1:0]          rhsValue;
  logic [xlen-1:0]          immediate;
  logic [1:0]               aluOp;
  logic                     aluSrc;
  logic                     memRead;
  logic                     memWrite;
  logic                     memToReg;
  logic                     regWrite;
  logic                     keepControls;

  assign lhsIndex = idInstruction.rFormat.rs1;
  assign rhsIndex = idInstruction.rFormat.rs2;

  // --------------------------------------------------
  // register file
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wbWrite) begin
      registers[wbIndex] <= wbData;
    end
  end

  // x0 reads as zero; a write in this cycle is passed straight through.
  assign lhsValue = (lhsIndex == '0) ? '0 :
                    (wbWrite && wbIndex == lhsIndex) ? wbData : registers[lhsIndex];
  assign rhsValue = (rhsIndex == '0) ? '0 :
                    (wbWrite && wbIndex == rhsIndex) ? wbData : registers[rhsIndex];

  // --------------------------------------------------
  // control and immediate
  // --------------------------------------------------
  always_comb begin
    aluOp    = aluOpMem;
    aluSrc   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    case (idInstruction.rFormat.opcode)
      opRType: begin
        aluOp    = aluOpReg;
        regWrite = 1'b1;
      end
      opIType: begin
        aluOp    = aluOpImm;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      opLoad: begin
        aluSrc   = 1'b1;
        memRead  = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      opStore: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      default: ; // anything else travels on as a bubble.
    endcase
  end

  always_comb begin
    if (idInstruction.sFormat.opcode == opStore) begin
      immediate = {{(xlen-12){idInstruction.sFormat.immHigh[6]}},
                   idInstruction.sFormat.immHigh, idInstruction.sFormat.immLow};
    end else begin
      immediate = {{(xlen-12){idInstruction.iFormat.imm12[11]}}, idInstruction.iFormat.imm12};
    end
  end

  // the load in execute has not read memory yet, so its consumer waits one cycle.
  assign stall = idValid && exMemRead &&
                 (exWriteIndex == lhsIndex || exWriteIndex == rhsIndex);
  assign keepControls = idValid && !stall;

  // --------------------------------------------------
  // decode/execute register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {exAluOp, exAluSrc, exMemRead, exMemWrite, exMemToReg, exRegWrite} <= '0;
    end else if (keepControls) begin
      {exAluOp, exAluSrc, exMemRead, exMemWrite, exMemToReg, exRegWrite} <=
        {aluOp, aluSrc, memRead, memWrite, memToReg, regWrite};
    end else begin
      {exAluOp, exAluSrc, exMemRead, exMemWrite, exMemToReg, exRegWrite} <= '0;
    end
  end

  always_ff @(posedge clk) begin
    exLhsValue   <= lhsValue;
    exRhsValue   <= rhsValue;
    exLhsIndex   <= lhsIndex;
    exRhsIndex   <= rhsIndex;
    exWriteIndex <= idInstruction.rFormat.rd;
    exImmediate  <= immediate;
    exFunct3     <= idInstruction.rFormat.funct3;
    exFunct7     <= idInstruction.rFormat.funct7;
  end

endmodule

//--- logic/FetchStage.sv
`timescale 1ns/1ps

module FetchStage (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic                             run,
  input  logic                             stall,
  input  logic                             imemLoad,
  input  logic [cpuPkg::imemAddrWidth-1:0] imemLoadAddress,
  input  logic [cpuPkg::xlen-1:0]          imemLoadData,
  output cpuPkg::instrWord                 idInstruction,
  output logic                             idValid
);
  import cpuPkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] instructionMemory [imemDepth];
  logic [xlen-1:0] fetchedWord;

  assign fetchedWord = instructionMemory[pc[imemAddrWidth+1:2]]; // drop the byte offset.

  always_ff @(posedge clk) begin
    if (imemLoad) begin
      instructionMemory[imemLoadAddress] <= imemLoadData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0; // the first fetch after run rises is word zero.
    end else if (!stall) begin
      pc <= pc + 4;
    end
  end

  // --------------------------------------------------
  // fetch/decode register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idValid <= 1'b0;
    end else if (!stall) begin
      idValid <= run;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      idInstruction <= fetchedWord;
    end
  end

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

  // --------------------------------------------------
  // widths and memory depths
  // --------------------------------------------------
  localparam int xlen          = 32;
  localparam int regIndexWidth = 5;
  localparam int imemDepth     = 64;
  localparam int dmemDepth     = 64;
  localparam int imemAddrWidth = $clog2(imemDepth); // word address, not byte.
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  // major opcodes of the supported subset.
  localparam logic [6:0] opRType = 7'b0110011;
  localparam logic [6:0] opIType = 7'b0010011;
  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  // ALU operation class handed from decode to execute.
  localparam logic [1:0] aluOpMem = 2'b00;
  localparam logic [1:0] aluOpReg = 2'b10;
  localparam logic [1:0] aluOpImm = 2'b11;

  localparam logic [3:0] aluAnd = 4'b0000;
  localparam logic [3:0] aluOr  = 4'b0001;
  localparam logic [3:0] aluAdd = 4'b0010;
  localparam logic [3:0] aluSub = 4'b0110;
  localparam logic [3:0] aluSlt = 4'b0111;

  // operand source picked by the forwarding logic.
  localparam logic [1:0] fwdNone      = 2'b00;
  localparam logic [1:0] fwdWriteback = 2'b01;
  localparam logic [1:0] fwdMemory    = 2'b10;

  // --------------------------------------------------
  // instruction word, seen through each base format
  // --------------------------------------------------
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rFormat;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } iFormat;
    struct packed {
      logic [6:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLow;
      logic [6:0] opcode;
    } sFormat;
  } instrWord;

endpackage
